//--- hdl/csr_pkg.sv
package csr_pkg;

    // Datapath widths.
    localparam int XLEN       = 32;
    localparam int PC_W       = 32;
    localparam int EXC_CODE_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int CSR_N_REGS = 13;
    localparam int CSR_IDX_W  = 4;

    // Architectural CSR addresses.
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MIP       = 12'h344;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MVENDORID = 12'hF11;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MARCHID   = 12'hF12;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MIMPID    = 12'hF13;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_MHARTID   = 12'hF14;

    // Physical register slots, same order as the addresses.
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MSTATUS   = 4'd0;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MISA      = 4'd1;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MIE       = 4'd2;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MTVEC     = 4'd3;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MSCRATCH  = 4'd4;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MEPC      = 4'd5;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MCAUSE    = 4'd6;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MTVAL     = 4'd7;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MIP       = 4'd8;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MVENDORID = 4'd9;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MARCHID   = 4'd10;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MIMPID    = 4'd11;
    localparam logic [CSR_IDX_W-1:0] CSR_IDX_MHARTID   = 4'd12;

    // Internal code, never a real cause.
    localparam logic [EXC_CODE_W-1:0] EXC_MRET = 5'd24;

    // mstatus layout.
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11; // Two bits wide.

    localparam logic [1:0] PRIV_M = 2'd3;

    // MXL = 1, extensions I, M, C and X.
    localparam logic [XLEN-1:0] MISA_RESET = 32'h4080_1104;

endpackage

//--- hdl/exc_report_if.sv
`timescale 1ns/1ps

interface exc_report_if;
    import csr_pkg::*;

    logic [PC_W-1:0]       pc;
    logic [EXC_CODE_W-1:0] code;
    logic [XLEN-1:0]       info;
    logic                  valid; // One report per cycle, always accepted.

    modport src (
        output pc,
        output code,
        output info,
        output valid
    );

    modport dst (
        input pc,
        input code,
        input info,
        input valid
    );

endinterface

//--- hdl/exc_prioritizer.sv
`timescale 1ns/1ps

module exc_prioritizer (
    input  logic [csr_pkg::PC_W-1:0]       dec_pc_i,
    input  logic [csr_pkg::EXC_CODE_W-1:0] dec_code_i,
    input  logic                           dec_valid_i,

    input  logic [csr_pkg::PC_W-1:0]       ex_pc_i,
    input  logic [csr_pkg::EXC_CODE_W-1:0] ex_code_i,
    input  logic [csr_pkg::XLEN-1:0]       ex_info_i,
    input  logic                           ex_valid_i,

    input  logic [csr_pkg::PC_W-1:0]       mem_pc_i,
    input  logic [csr_pkg::EXC_CODE_W-1:0] mem_code_i,
    input  logic                           mem_valid_i,

    exc_report_if.src                      rpt
);
    import csr_pkg::*;

    logic [PC_W-1:0]       sel_pc;
    logic [EXC_CODE_W-1:0] sel_code;
    logic [XLEN-1:0]       sel_info;

    // Oldest instruction wins.
    always_comb begin
        sel_pc   = '0;
        sel_code = '0;
        sel_info = '0;
        if (mem_valid_i) begin
            sel_pc   = mem_pc_i;
            sel_code = mem_code_i;
        end else if (ex_valid_i) begin
            sel_pc   = ex_pc_i;
            sel_code = ex_code_i;
            sel_info = ex_info_i; // Only execute carries a trap value.
        end else if (dec_valid_i) begin
            sel_pc   = dec_pc_i;
            sel_code = dec_code_i;
        end
    end

    assign rpt.pc    = sel_pc;
    assign rpt.code  = sel_code;
    assign rpt.info  = sel_info;
    assign rpt.valid = mem_valid_i | ex_valid_i | dec_valid_i;

endmodule

//--- hdl/csr_addr_map.sv
`timescale 1ns/1ps

module csr_addr_map (
    input  logic [csr_pkg::CSR_ADDR_W-1:0] addr_i,
    output logic [csr_pkg::CSR_IDX_W-1:0]  idx_o,
    output logic                           hit_o,
    output logic                           writable_o
);
    import csr_pkg::*;

    always_comb begin
        idx_o      = '0;
        hit_o      = 1'b1;
        writable_o = 1'b1;
        case (addr_i)
            CSR_ADDR_MSTATUS:  idx_o = CSR_IDX_MSTATUS;
            CSR_ADDR_MIE:      idx_o = CSR_IDX_MIE;
            CSR_ADDR_MTVEC:    idx_o = CSR_IDX_MTVEC;
            CSR_ADDR_MSCRATCH: idx_o = CSR_IDX_MSCRATCH;
            CSR_ADDR_MEPC:     idx_o = CSR_IDX_MEPC;
            CSR_ADDR_MCAUSE:   idx_o = CSR_IDX_MCAUSE;
            CSR_ADDR_MTVAL:    idx_o = CSR_IDX_MTVAL;
            CSR_ADDR_MIP:      idx_o = CSR_IDX_MIP;
            // Identification registers are read-only.
            CSR_ADDR_MISA: begin
                idx_o      = CSR_IDX_MISA;
                writable_o = 1'b0;
            end
            CSR_ADDR_MVENDORID: begin
                idx_o      = CSR_IDX_MVENDORID;
                writable_o = 1'b0;
            end
            CSR_ADDR_MARCHID: begin
                idx_o      = CSR_IDX_MARCHID;
                writable_o = 1'b0;
            end
            CSR_ADDR_MIMPID: begin
                idx_o      = CSR_IDX_MIMPID;
                writable_o = 1'b0;
            end
            CSR_ADDR_MHARTID: begin
                idx_o      = CSR_IDX_MHARTID;
                writable_o = 1'b0;
            end
            default: begin
                hit_o      = 1'b0; // Unimplemented address.
                writable_o = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                           clk_i,
    input  logic                           rstn_i,

    exc_report_if.dst                      rpt,

    input  logic [csr_pkg::CSR_ADDR_W-1:0] rd_addr_i,
    input  logic                           rd_valid_i,

    input  logic [csr_pkg::CSR_ADDR_W-1:0] wr_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       wr_data_i,
    input  logic                           wr_valid_i,

    output logic [csr_pkg::XLEN-1:0]       rd_data_o,
    output logic                           rd_illegal_o,

    output logic [csr_pkg::PC_W-1:0]       redirect_pc_o,
    output logic                           redirect_valid_o
);
    import csr_pkg::*;

    logic [XLEN-1:0]      csr_q [CSR_N_REGS];
    logic [XLEN-1:0]      csr_d [CSR_N_REGS];

    logic [CSR_IDX_W-1:0] rd_idx;
    logic                 rd_hit;
    logic [CSR_IDX_W-1:0] wr_idx;
    logic                 wr_hit;
    logic                 wr_writable;
    logic                 wr_en;

    logic                 is_mret;
    logic                 trap_entry;
    logic                 trap_return;
    logic [XLEN-1:0]      mstatus_q;
    logic [PC_W-1:0]      mtvec_base;

    csr_addr_map u_rd_map (
        .addr_i     (rd_addr_i),
        .idx_o      (rd_idx),
        .hit_o      (rd_hit),
        .writable_o ()
    );

    csr_addr_map u_wr_map (
        .addr_i     (wr_addr_i),
        .idx_o      (wr_idx),
        .hit_o      (wr_hit),
        .writable_o (wr_writable)
    );

    assign is_mret     = (rpt.code == EXC_MRET);
    assign trap_entry  = rpt.valid & ~is_mret;
    assign trap_return = rpt.valid & is_mret;
    assign wr_en       = wr_valid_i & wr_hit & wr_writable;

    assign mstatus_q  = csr_q[CSR_IDX_MSTATUS];
    assign mtvec_base = {csr_q[CSR_IDX_MTVEC][PC_W-1:2], 2'b00}; // Direct mode only.

    // Next state of the register file.
    always_comb begin
        csr_d = csr_q;

        if (trap_entry) begin
            csr_d[CSR_IDX_MEPC]   = rpt.pc;
            csr_d[CSR_IDX_MCAUSE] = {{(XLEN-EXC_CODE_W){1'b0}}, rpt.code};
            csr_d[CSR_IDX_MTVAL]  = rpt.info;
            csr_d[CSR_IDX_MSTATUS][MSTATUS_MPIE]        = mstatus_q[MSTATUS_MIE];
            csr_d[CSR_IDX_MSTATUS][MSTATUS_MIE]         = 1'b0;
            csr_d[CSR_IDX_MSTATUS][MSTATUS_MPP_LO +: 2] = PRIV_M;
        end

        // Return from trap, mepc/mcause/mtval untouched.
        if (trap_return) begin
            csr_d[CSR_IDX_MSTATUS][MSTATUS_MIE]  = mstatus_q[MSTATUS_MPIE];
            csr_d[CSR_IDX_MSTATUS][MSTATUS_MPIE] = 1'b1;
        end

        // Software write overrides trap side effects on the same register.
        if (wr_en) begin
            csr_d[wr_idx] = wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < CSR_N_REGS; i++) begin
                csr_q[i] <= '0;
            end
            csr_q[CSR_IDX_MISA] <= MISA_RESET;
        end else begin
            csr_q <= csr_d;
        end
    end

    // Read port sees the registered value only.
    always_comb begin
        rd_data_o    = '0;
        rd_illegal_o = 1'b0;
        if (rd_valid_i) begin
            if (rd_hit) begin
                rd_data_o = csr_q[rd_idx];
            end else begin
                rd_illegal_o = 1'b1;
            end
        end
    end

    // Fetch redirect, doubles as pipeline flush.
    always_comb begin
        redirect_valid_o = rpt.valid;
        redirect_pc_o    = '0;
        if (trap_return) begin
            redirect_pc_o = csr_q[CSR_IDX_MEPC];
        end else if (trap_entry) begin
            redirect_pc_o = mtvec_base;
        end
    end

endmodule

//--- hdl/trap_csr_unit.sv
`timescale 1ns/1ps

module trap_csr_unit (
    input  logic                           clk_i,
    input  logic                           rstn_i,

    input  logic [csr_pkg::PC_W-1:0]       dec_exc_pc_i,
    input  logic [csr_pkg::EXC_CODE_W-1:0] dec_exc_code_i,
    input  logic                           dec_exc_valid_i,

    input  logic [csr_pkg::PC_W-1:0]       ex_exc_pc_i,
    input  logic [csr_pkg::EXC_CODE_W-1:0] ex_exc_code_i,
    input  logic [csr_pkg::XLEN-1:0]       ex_exc_info_i,
    input  logic                           ex_exc_valid_i,

    input  logic [csr_pkg::PC_W-1:0]       mem_exc_pc_i,
    input  logic [csr_pkg::EXC_CODE_W-1:0] mem_exc_code_i,
    input  logic                           mem_exc_valid_i,

    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_rd_addr_i,
    input  logic                           csr_rd_valid_i,

    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_wr_addr_i,
    input  logic [csr_pkg::XLEN-1:0]       csr_wr_data_i,
    input  logic                           csr_wr_valid_i,

    output logic [csr_pkg::XLEN-1:0]       csr_rd_data_o,
    output logic                           csr_rd_illegal_o,

    output logic [csr_pkg::PC_W-1:0]       redirect_pc_o,
    output logic                           redirect_valid_o // Also flushes the pipeline.
);

    exc_report_if u_rpt_if ();

    exc_prioritizer u_prio (
        .dec_pc_i    (dec_exc_pc_i),
        .dec_code_i  (dec_exc_code_i),
        .dec_valid_i (dec_exc_valid_i),
        .ex_pc_i     (ex_exc_pc_i),
        .ex_code_i   (ex_exc_code_i),
        .ex_info_i   (ex_exc_info_i),
        .ex_valid_i  (ex_exc_valid_i),
        .mem_pc_i    (mem_exc_pc_i),
        .mem_code_i  (mem_exc_code_i),
        .mem_valid_i (mem_exc_valid_i),
        .rpt         (u_rpt_if.src)
    );

    csr_file u_csr (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .rpt              (u_rpt_if.dst),
        .rd_addr_i        (csr_rd_addr_i),
        .rd_valid_i       (csr_rd_valid_i),
        .wr_addr_i        (csr_wr_addr_i),
        .wr_data_i        (csr_wr_data_i),
        .wr_valid_i       (csr_wr_valid_i),
        .rd_data_o        (csr_rd_data_o),
        .rd_illegal_o     (csr_rd_illegal_o),
        .redirect_pc_o    (redirect_pc_o),
        .redirect_valid_o (redirect_valid_o)
    );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o; // 4 ns period.
    end

    // Reset held over two rising edges, released on a falling edge.
    initial begin
        rstn_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

//--- verification/trap_csr_props.sv
`timescale 1ns/1ps

module trap_csr_props (
    input logic clk_i,
    input logic rstn_i,
    input logic dec_exc_valid_i,
    input logic ex_exc_valid_i,
    input logic mem_exc_valid_i,
    input logic csr_rd_valid_i,
    input logic csr_rd_illegal_o,
    input logic redirect_valid_o
);

    int fail_count = 0;

    logic any_stage_valid;

    assign any_stage_valid = dec_exc_valid_i | ex_exc_valid_i | mem_exc_valid_i;

    // A flush always has a cause.
    redirect_has_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_valid_o |-> any_stage_valid)
        else begin
            $error("redirect_valid_o high with no stage report valid");
            fail_count++;
        end

    illegal_needs_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
        csr_rd_illegal_o |-> csr_rd_valid_i)
        else begin
            $error("csr_rd_illegal_o high without a read");
            fail_count++;
        end

    // Under reset the redirect is still purely combinational from the stages.
    redirect_in_reset: assert property (@(posedge clk_i)
        !rstn_i |-> (redirect_valid_o == any_stage_valid))
        else begin
            $error("redirect_valid_o does not follow the stage valids in reset");
            fail_count++;
        end

endmodule

//--- verification/trap_csr_tb.sv
`timescale 1ns/1ps

module trap_csr_tb;
    import csr_pkg::*;

    localparam int RAND_CYCLES = 2000;
    localparam int MAX_CYCLES  = 2100; // Reset, directed steps, random run, margin.

    logic                  clk;
    logic                  rstn;
    logic [PC_W-1:0]       dec_pc;
    logic [EXC_CODE_W-1:0] dec_code;
    logic                  dec_valid;
    logic [PC_W-1:0]       ex_pc;
    logic [EXC_CODE_W-1:0] ex_code;
    logic [XLEN-1:0]       ex_info;
    logic                  ex_valid;
    logic [PC_W-1:0]       mem_pc;
    logic [EXC_CODE_W-1:0] mem_code;
    logic                  mem_valid;
    logic [CSR_ADDR_W-1:0] rd_addr;
    logic                  rd_valid;
    logic [CSR_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;
    logic                  wr_valid;
    logic [XLEN-1:0]       rd_data;
    logic                  rd_illegal;
    logic [PC_W-1:0]       redirect_pc;
    logic                  redirect_valid;

    logic [CSR_ADDR_W-1:0] addr_table [CSR_N_REGS]; // Address of each register slot.
    logic [XLEN-1:0]       model [CSR_N_REGS];
    int                    seed;
    int                    cycles = 0;

    tb_clk_gen u_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    trap_csr_unit i_trap_csr_unit (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .dec_exc_pc_i     (dec_pc),
        .dec_exc_code_i   (dec_code),
        .dec_exc_valid_i  (dec_valid),
        .ex_exc_pc_i      (ex_pc),
        .ex_exc_code_i    (ex_code),
        .ex_exc_info_i    (ex_info),
        .ex_exc_valid_i   (ex_valid),
        .mem_exc_pc_i     (mem_pc),
        .mem_exc_code_i   (mem_code),
        .mem_exc_valid_i  (mem_valid),
        .csr_rd_addr_i    (rd_addr),
        .csr_rd_valid_i   (rd_valid),
        .csr_wr_addr_i    (wr_addr),
        .csr_wr_data_i    (wr_data),
        .csr_wr_valid_i   (wr_valid),
        .csr_rd_data_o    (rd_data),
        .csr_rd_illegal_o (rd_illegal),
        .redirect_pc_o    (redirect_pc),
        .redirect_valid_o (redirect_valid)
    );

    bind trap_csr_unit trap_csr_props u_props (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .dec_exc_valid_i  (dec_exc_valid_i),
        .ex_exc_valid_i   (ex_exc_valid_i),
        .mem_exc_valid_i  (mem_exc_valid_i),
        .csr_rd_valid_i   (csr_rd_valid_i),
        .csr_rd_illegal_o (csr_rd_illegal_o),
        .redirect_valid_o (redirect_valid_o)
    );

    // Linear search of the architectural address table.
    task automatic lookup(input logic [CSR_ADDR_W-1:0] addr, output int idx, output bit hit);
        idx = 0;
        hit = 1'b0;
        for (int i = 0; i < CSR_N_REGS; i++) begin
            if (addr_table[i] == addr) begin
                idx = i;
                hit = 1'b1;
            end
        end
    endtask

    function automatic bit is_read_only(input int idx);
        return (idx == CSR_IDX_MISA) || (idx >= CSR_IDX_MVENDORID);
    endfunction

    function automatic logic [EXC_CODE_W-1:0] draw_code();
        if (($random(seed) & 3) == 0) begin
            return EXC_MRET;
        end
        return EXC_CODE_W'($unsigned($random(seed)) % 16);
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] draw_addr();
        if (($random(seed) & 7) == 0) begin
            return CSR_ADDR_W'($random(seed)); // Now and then an unknown address.
        end
        return addr_table[$unsigned($random(seed)) % CSR_N_REGS];
    endfunction

    task automatic check_rd_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    task automatic check_redirect_pc(input logic [PC_W-1:0] got, input logic [PC_W-1:0] exp,
                                     input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Stopping at the first mismatch.");
        end
    endtask

    // Bound assertions count their failures.
    task automatic check_assertions();
        if (i_trap_csr_unit.u_props.fail_count != 0) begin
            $display("An assertion in trap_csr_props failed before %0t.", $time);
            $display("TEST FAIL");
            $fatal(1, "Assertion failure.");
        end
    endtask

    task automatic drive_idle();
        dec_pc    = '0;
        dec_code  = '0;
        dec_valid = 1'b0;
        ex_pc     = '0;
        ex_code   = '0;
        ex_info   = '0;
        ex_valid  = 1'b0;
        mem_pc    = '0;
        mem_code  = '0;
        mem_valid = 1'b0;
        rd_addr   = '0;
        rd_valid  = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        wr_valid  = 1'b0;
    endtask

    task automatic drive_random();
        dec_pc    = $random(seed);
        dec_code  = draw_code();
        dec_valid = ($random(seed) & 7) == 0;
        ex_pc     = $random(seed);
        ex_code   = draw_code();
        ex_info   = $random(seed);
        ex_valid  = ($random(seed) & 7) == 0;
        mem_pc    = $random(seed);
        mem_code  = draw_code();
        mem_valid = ($random(seed) & 7) == 0;
        rd_addr   = draw_addr();
        rd_valid  = ($random(seed) & 3) != 0;
        wr_addr   = draw_addr();
        wr_data   = $random(seed);
        wr_valid  = ($random(seed) & 1) != 0;
    endtask

    // Memory over execute over decode, info only from execute.
    task automatic select_report(output logic [PC_W-1:0] pc, output logic [EXC_CODE_W-1:0] code,
                                 output logic [XLEN-1:0] info);
        pc   = '0;
        code = '0;
        info = '0;
        if (mem_valid) begin
            pc   = mem_pc;
            code = mem_code;
        end else if (ex_valid) begin
            pc   = ex_pc;
            code = ex_code;
            info = ex_info;
        end else if (dec_valid) begin
            pc   = dec_pc;
            code = dec_code;
        end
    endtask

    task automatic check_outputs();
        logic [XLEN-1:0]       exp_data;
        logic                  exp_illegal;
        logic                  any_valid;
        logic [PC_W-1:0]       pc;
        logic [EXC_CODE_W-1:0] code;
        logic [XLEN-1:0]       info;
        int                    idx;
        bit                    hit;
        lookup(rd_addr, idx, hit);
        exp_data    = '0;
        exp_illegal = 1'b0;
        if (rd_valid) begin
            if (hit) begin
                exp_data = model[idx];
            end else begin
                exp_illegal = 1'b1;
            end
        end
        check_rd_data(rd_data, exp_data, "csr read data");
        check_flag(rd_illegal, exp_illegal, "csr read illegal");
        any_valid = dec_valid | ex_valid | mem_valid;
        check_flag(redirect_valid, any_valid, "redirect valid");
        if (any_valid) begin
            select_report(pc, code, info);
            if (code == EXC_MRET) begin
                check_redirect_pc(redirect_pc, model[CSR_IDX_MEPC], "mret redirect pc");
            end else begin
                check_redirect_pc(redirect_pc, {model[CSR_IDX_MTVEC][PC_W-1:2], 2'b00},
                                  "trap redirect pc");
            end
        end
    endtask

    task automatic update_model();
        logic [PC_W-1:0]       pc;
        logic [EXC_CODE_W-1:0] code;
        logic [XLEN-1:0]       info;
        logic [XLEN-1:0]       ms;
        int                    idx;
        bit                    hit;
        select_report(pc, code, info);
        ms = model[CSR_IDX_MSTATUS];
        if (dec_valid | ex_valid | mem_valid) begin
            if (code == EXC_MRET) begin
                ms[MSTATUS_MIE]  = ms[MSTATUS_MPIE];
                ms[MSTATUS_MPIE] = 1'b1;
            end else begin
                model[CSR_IDX_MEPC]   = pc;
                model[CSR_IDX_MCAUSE] = XLEN'(code);
                model[CSR_IDX_MTVAL]  = info;
                ms[MSTATUS_MPIE]         = ms[MSTATUS_MIE];
                ms[MSTATUS_MIE]          = 1'b0;
                ms[MSTATUS_MPP_LO +: 2]  = PRIV_M;
            end
            model[CSR_IDX_MSTATUS] = ms;
        end
        lookup(wr_addr, idx, hit);
        if (wr_valid && hit && !is_read_only(idx)) begin
            model[idx] = wr_data; // Write beats the trap on the same slot.
        end
    endtask

    // Called at a falling edge once the inputs are set.
    task automatic step();
        #1;
        check_assertions();
        check_outputs();
        update_model();
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "Timeout.");
        end
    end

    initial begin
        seed = 82;
        drive_idle();
        addr_table = '{CSR_ADDR_MSTATUS, CSR_ADDR_MISA, CSR_ADDR_MIE, CSR_ADDR_MTVEC,
                       CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL,
                       CSR_ADDR_MIP, CSR_ADDR_MVENDORID, CSR_ADDR_MARCHID, CSR_ADDR_MIMPID,
                       CSR_ADDR_MHARTID};
        for (int i = 0; i < CSR_N_REGS; i++) begin
            model[i] = '0;
        end
        model[CSR_IDX_MISA] = MISA_RESET;
        wait (rstn === 1'b1);
        @(negedge clk);

        // Reset values of every slot.
        for (int i = 0; i < CSR_N_REGS; i++) begin
            drive_idle();
            rd_addr  = addr_table[i];
            rd_valid = 1'b1;
            step();
        end

        // Unknown read, writes to read-only and unknown addresses.
        drive_idle();
        rd_addr  = 12'h7C0;
        rd_valid = 1'b1;
        wr_addr  = CSR_ADDR_MISA;
        wr_data  = 32'hDEAD_BEEF;
        wr_valid = 1'b1;
        step();
        drive_idle();
        rd_addr  = CSR_ADDR_MISA;
        rd_valid = 1'b1;
        wr_addr  = 12'h7C0;
        wr_data  = 32'h1234_5678;
        wr_valid = 1'b1;
        step();

        // All stages at once, with a write to mcause in the same cycle.
        drive_idle();
        dec_pc    = 32'h0000_1000;
        dec_code  = 5'd2;
        dec_valid = 1'b1;
        ex_pc     = 32'h0000_0FFC;
        ex_code   = 5'd5;
        ex_info   = 32'hA5A5_0001;
        ex_valid  = 1'b1;
        mem_pc    = 32'h0000_0FF8;
        mem_code  = 5'd7;
        mem_valid = 1'b1;
        wr_addr   = CSR_ADDR_MCAUSE;
        wr_data   = 32'hCAFE_0001;
        wr_valid  = 1'b1;
        step();
        for (int i = CSR_IDX_MEPC; i <= CSR_IDX_MTVAL; i++) begin
            drive_idle();
            rd_addr  = addr_table[i];
            rd_valid = 1'b1;
            step();
        end

        for (int n = 0; n < RAND_CYCLES; n++) begin
            drive_random();
            step();
        end

        if (i_trap_csr_unit.u_props.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/csr_pkg.sv
hdl/exc_report_if.sv
hdl/exc_prioritizer.sv
hdl/csr_addr_map.sv
hdl/csr_file.sv
hdl/trap_csr_unit.sv
verification/tb_clk_gen.sv
verification/trap_csr_props.sv
verification/trap_csr_tb.sv

//--- Bender.yml
package:
  name: trap_csr_unit

sources:
  - files:
      - hdl/csr_pkg.sv
      - hdl/exc_report_if.sv
      - hdl/exc_prioritizer.sv
      - hdl/csr_addr_map.sv
      - hdl/csr_file.sv
      - hdl/trap_csr_unit.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/trap_csr_props.sv
      - verification/trap_csr_tb.sv

# Simulation top: trap_csr_tb
# RTL top: trap_csr_unit
# File list for other flows: src.f
